/* source/periph_pkg.sv */
package periph_pkg;

   // Shared peripheral bus widths
   localparam int addr_w = 12;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;

   // Each peripheral owns a fixed 256 byte window
   localparam int win_w = 8;

   // Window base addresses
   localparam logic [addr_w-1:0] gpio_base  = 12'h000;
   localparam logic [addr_w-1:0] timer_base = 12'h100;

   // Register offsets
   // Bit 8 carries the window tag so GPIO and timer offsets stay distinct
   typedef enum logic [win_w:0] {
      reg_gpio_out   = 9'h000,
      reg_gpio_in    = 9'h004,
      reg_tmr_ctrl   = 9'h100,
      reg_tmr_count  = 9'h104,
      reg_tmr_cmp    = 9'h108,
      reg_tmr_status = 9'h10C
   } reg_off_e;

   // Arbiter FSM states
   typedef enum logic [1:0] {
      arb_idle,
      arb_setup,
      arb_access
   } arb_state_e;

   // Byte-strobed register update
   function automatic logic [data_w-1:0] merge_bytes(
      input logic [data_w-1:0] old_val,
      input logic [data_w-1:0] new_val,
      input logic [strb_w-1:0] strb
   );
      logic [data_w-1:0] res;
      res = old_val;
      for (int i = 0; i < strb_w; i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = new_val[i*8 +: 8];
         end
      end
      return res;
   endfunction

endpackage

/* source/periph_arbiter.sv */
module periph_arbiter #(
   parameter int addr_w = periph_pkg::addr_w
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          m0_psel,
   input  logic                          m0_penable,
   input  logic                          m0_pwrite,
   input  logic [addr_w-1:0]             m0_paddr,
   input  logic [periph_pkg::data_w-1:0] m0_pwdata,
   input  logic [periph_pkg::strb_w-1:0] m0_pstrb,
   output logic [periph_pkg::data_w-1:0] m0_prdata,
   output logic                          m0_pready,
   output logic                          m0_pslverr,
   input  logic                          m1_psel,
   input  logic                          m1_penable,
   input  logic                          m1_pwrite,
   input  logic [addr_w-1:0]             m1_paddr,
   input  logic [periph_pkg::data_w-1:0] m1_pwdata,
   input  logic [periph_pkg::strb_w-1:0] m1_pstrb,
   output logic [periph_pkg::data_w-1:0] m1_prdata,
   output logic                          m1_pready,
   output logic                          m1_pslverr,
   output logic                          bus_sel,
   output logic                          bus_enable,
   output logic                          bus_write,
   output logic [addr_w-1:0]             bus_addr,
   output logic [periph_pkg::data_w-1:0] bus_wdata,
   output logic [periph_pkg::strb_w-1:0] bus_strb,
   input  logic [periph_pkg::data_w-1:0] bus_rdata,
   input  logic                          bus_ready,
   input  logic                          bus_slverr
);
   import periph_pkg::*;

   arb_state_e        state;
   // Grant and last grant: 0 is m0, 1 is m1
   logic              grant;
   logic              last_grant;
   logic              next_grant;
   logic              any_req;
   logic              done;
   logic              cap_write;
   logic [addr_w-1:0] cap_addr;
   logic [data_w-1:0] cap_wdata;
   logic [strb_w-1:0] cap_strb;

   assign any_req = m0_psel || m1_psel;

   // Round-robin pick, the master not served last wins a tie
   always_comb begin
      if (m0_psel && m1_psel) begin
         next_grant = ~last_grant;
      end else begin
         next_grant = m1_psel;
      end
   end

   assign done = (state == arb_access) && bus_ready;

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         state      <= arb_idle;
         grant      <= 1'b0;
         // m0 wins the first tie
         last_grant <= 1'b1;
      end else begin
         case (state)
            arb_idle: begin
               if (any_req) begin
                  state <= arb_setup;
                  grant <= next_grant;
               end
            end
            arb_setup: state <= arb_access;
            arb_access: begin
               if (bus_ready) begin
                  state      <= arb_idle;
                  last_grant <= grant;
               end
            end
            default: state <= arb_idle;
         endcase
      end
   end

   // Captured request of the granted master
   always_ff @(posedge clk) begin
      if (state == arb_idle && any_req) begin
         cap_write <= next_grant ? m1_pwrite : m0_pwrite;
         cap_addr  <= next_grant ? m1_paddr : m0_paddr;
         cap_wdata <= next_grant ? m1_pwdata : m0_pwdata;
         cap_strb  <= next_grant ? m1_pstrb : m0_pstrb;
      end
   end

   // Shared bus phases
   assign bus_sel    = (state != arb_idle);
   assign bus_enable = (state == arb_access);
   assign bus_write  = cap_write;
   assign bus_addr   = cap_addr;
   assign bus_wdata  = cap_wdata;
   assign bus_strb   = cap_strb;

   // Response goes back only to the granted master
   assign m0_pready  = done && !grant;
   assign m1_pready  = done && grant;
   assign m0_prdata  = m0_pready ? bus_rdata : '0;
   assign m1_prdata  = m1_pready ? bus_rdata : '0;
   assign m0_pslverr = m0_pready && bus_slverr;
   assign m1_pslverr = m1_pready && bus_slverr;

   // Only one master completes, and only inside its own access phase
   a_m0_grant: assert property (@(posedge clk) disable iff (rst_n)
      m0_pready |-> m0_penable && !m1_pready)
      else $error("m0 ready outside its access phase or together with m1");
   a_m1_grant: assert property (@(posedge clk) disable iff (rst_n)
      m1_pready |-> m1_penable)
      else $error("m1 ready outside its access phase");

   // Access phase always comes right after a setup phase
   a_enable_after_sel: assert property (@(posedge clk) disable iff (rst_n)
      $rose(bus_enable) |-> bus_sel && $past(bus_sel) && !$past(bus_enable))
      else $error("bus enable without a preceding setup phase");

   // Address and direction hold from setup through access
   a_addr_stable: assert property (@(posedge clk) disable iff (rst_n)
      bus_enable |-> $stable(bus_addr) && $stable(bus_write))
      else $error("bus address changed during the access phase");

endmodule

/* source/periph_bus_decode.sv */
module periph_bus_decode #(
   parameter int addr_w = periph_pkg::addr_w
) (
   input  logic                          bus_sel,
   input  logic                          bus_enable,
   input  logic [addr_w-1:0]             bus_addr,
   output logic                          gpio_sel,
   output logic                          timer_sel,
   input  logic [periph_pkg::data_w-1:0] gpio_rdata,
   input  logic [periph_pkg::data_w-1:0] timer_rdata,
   output logic [periph_pkg::data_w-1:0] bus_rdata,
   output logic                          bus_ready,
   output logic                          bus_slverr
);
   import periph_pkg::*;

   // Base addresses sized to this bus
   localparam logic [addr_w-1:0] gpio_page  = addr_w'(gpio_base);
   localparam logic [addr_w-1:0] timer_page = addr_w'(timer_base);

   logic gpio_hit;
   logic timer_hit;

   // Only the bits above the window offset pick the target
   assign gpio_hit  = (bus_addr[addr_w-1:win_w] == gpio_page[addr_w-1:win_w]);
   assign timer_hit = (bus_addr[addr_w-1:win_w] == timer_page[addr_w-1:win_w]);

   assign gpio_sel  = bus_sel && gpio_hit;
   assign timer_sel = bus_sel && timer_hit;

   // Read data from whichever target is selected
   always_comb begin
      if (gpio_sel) begin
         bus_rdata = gpio_rdata;
      end else if (timer_sel) begin
         bus_rdata = timer_rdata;
      end else begin
         // Unmapped reads return zero
         bus_rdata = '0;
      end
   end

   // All targets are zero wait
   assign bus_ready  = bus_enable;
   // Error response for an access outside both windows
   assign bus_slverr = bus_sel && bus_enable && !(gpio_hit || timer_hit);

endmodule

/* source/periph_gpio_ctrl.sv */
module periph_gpio_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          sel,
   input  logic                          enable,
   input  logic                          write,
   input  logic [periph_pkg::win_w-1:0]  offset,
   input  logic [periph_pkg::data_w-1:0] wdata,
   input  logic [periph_pkg::strb_w-1:0] strb,
   output logic [periph_pkg::data_w-1:0] rdata,
   input  logic [periph_pkg::data_w-1:0] pad_in,
   output logic [periph_pkg::data_w-1:0] pad_out
);
   import periph_pkg::*;

   logic [data_w-1:0] out_q;
   logic [data_w-1:0] in_meta;
   logic [data_w-1:0] in_sync;
   logic              out_wr;
   reg_off_e          reg_sel;

   // GPIO window has tag bit 0
   assign reg_sel = reg_off_e'({1'b0, offset});

   // Output register write in the access phase
   assign out_wr = sel && enable && write && (reg_sel == reg_gpio_out);

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         out_q   <= '0;
         in_meta <= '0;
         in_sync <= '0;
      end else begin
         // Two flop synchronizer on the pads
         in_meta <= pad_in;
         in_sync <= in_meta;
         // Untouched bytes keep their value
         if (out_wr) begin
            out_q <= merge_bytes(out_q, wdata, strb);
         end
      end
   end

   assign pad_out = out_q;

   // Readback mux
   always_comb begin
      case (reg_sel)
         reg_gpio_out: rdata = out_q;
         reg_gpio_in:  rdata = in_sync;
         default:      rdata = '0;
      endcase
   end

endmodule

/* source/periph_timer.sv */
module periph_timer (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          sel,
   input  logic                          enable,
   input  logic                          write,
   input  logic [periph_pkg::win_w-1:0]  offset,
   input  logic [periph_pkg::data_w-1:0] wdata,
   input  logic [periph_pkg::strb_w-1:0] strb,
   output logic [periph_pkg::data_w-1:0] rdata,
   output logic                          irq
);
   import periph_pkg::*;

   logic              tmr_en;
   logic [data_w-1:0] count;
   logic [data_w-1:0] cmp;
   logic              match;
   logic              wr;
   logic              hit;
   logic              clr;
   reg_off_e          reg_sel;

   // Timer window has tag bit 1
   assign reg_sel = reg_off_e'({1'b1, offset});

   assign wr  = sel && enable && write;
   // Compare only counts while running
   assign hit = tmr_en && (count == cmp);
   // Write one to status bit 0 clears the flag
   assign clr = wr && (reg_sel == reg_tmr_status) && strb[0] && wdata[0];

   always_ff @(posedge clk or posedge rst_n) begin
      if (rst_n) begin
         tmr_en <= 1'b0;
         count  <= '0;
         cmp    <= '0;
         match  <= 1'b0;
         irq    <= 1'b0;
      end else begin
         if (wr && (reg_sel == reg_tmr_ctrl) && strb[0]) begin
            tmr_en <= wdata[0];
         end
         // Software load has priority over counting
         if (wr && (reg_sel == reg_tmr_count)) begin
            count <= merge_bytes(count, wdata, strb);
         end else if (tmr_en) begin
            count <= count + 1'b1;
         end
         if (wr && (reg_sel == reg_tmr_cmp)) begin
            cmp <= merge_bytes(cmp, wdata, strb);
         end
         // Sticky flag, a new match beats a clear
         if (hit) begin
            match <= 1'b1;
         end else if (clr) begin
            match <= 1'b0;
         end
         // Interrupt tracks the next flag value
         irq <= hit || (match && !clr);
      end
   end

   // Register readback
   always_comb begin
      case (reg_sel)
         reg_tmr_ctrl:   rdata = {{(data_w-1){1'b0}}, tmr_en};
         reg_tmr_count:  rdata = count;
         reg_tmr_cmp:    rdata = cmp;
         reg_tmr_status: rdata = {{(data_w-1){1'b0}}, match};
         default:        rdata = '0;
      endcase
   end

   a_irq_has_flag: assert property (@(posedge clk) disable iff (rst_n)
      irq |-> match)
      else $error("timer irq high without the match flag");

endmodule

/* source/periph_top.sv */
module periph_top #(
   parameter int addr_w = periph_pkg::addr_w
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          m0_psel,
   input  logic                          m0_penable,
   input  logic                          m0_pwrite,
   input  logic [addr_w-1:0]             m0_paddr,
   input  logic [periph_pkg::data_w-1:0] m0_pwdata,
   input  logic [periph_pkg::strb_w-1:0] m0_pstrb,
   output logic [periph_pkg::data_w-1:0] m0_prdata,
   output logic                          m0_pready,
   output logic                          m0_pslverr,
   input  logic                          m1_psel,
   input  logic                          m1_penable,
   input  logic                          m1_pwrite,
   input  logic [addr_w-1:0]             m1_paddr,
   input  logic [periph_pkg::data_w-1:0] m1_pwdata,
   input  logic [periph_pkg::strb_w-1:0] m1_pstrb,
   output logic [periph_pkg::data_w-1:0] m1_prdata,
   output logic                          m1_pready,
   output logic                          m1_pslverr,
   input  logic [periph_pkg::data_w-1:0] gpio_pad_in,
   output logic [periph_pkg::data_w-1:0] gpio_pad_out,
   output logic                          timer_irq
);
   import periph_pkg::*;

   // Shared bus after the arbiter
   logic              bus_sel;
   logic              bus_enable;
   logic              bus_write;
   logic [addr_w-1:0] bus_addr;
   logic [data_w-1:0] bus_wdata;
   logic [strb_w-1:0] bus_strb;
   logic [data_w-1:0] bus_rdata;
   logic              bus_ready;
   logic              bus_slverr;

   // Per-target selects and read data
   logic              gpio_sel;
   logic              timer_sel;
   logic [data_w-1:0] gpio_rdata;
   logic [data_w-1:0] timer_rdata;

   periph_arbiter #(.addr_w(addr_w)) arb_i (.*);

   periph_bus_decode #(.addr_w(addr_w)) dec_i (.*);

   periph_gpio_ctrl gpio_i (
      .clk,
      .rst_n,
      .sel     (gpio_sel),
      .enable  (bus_enable),
      .write   (bus_write),
      .offset  (bus_addr[win_w-1:0]),
      .wdata   (bus_wdata),
      .strb    (bus_strb),
      .rdata   (gpio_rdata),
      .pad_in  (gpio_pad_in),
      .pad_out (gpio_pad_out)
   );

   periph_timer timer_i (
      .clk,
      .rst_n,
      .sel    (timer_sel),
      .enable (bus_enable),
      .write  (bus_write),
      .offset (bus_addr[win_w-1:0]),
      .wdata  (bus_wdata),
      .strb   (bus_strb),
      .rdata  (timer_rdata),
      .irq    (timer_irq)
   );

endmodule

/* testbench/periph_tb.sv */
module periph_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic             clk;
   logic             rst_n;
   // Master side signals, index 0 is the CPU port and index 1 the debug port
   logic [1:0]       psel;
   logic [1:0]       penable;
   logic [1:0]       pwrite;
   logic [1:0][11:0] paddr;
   logic [1:0][31:0] pwdata;
   logic [1:0][3:0]  pstrb;
   wire  [1:0][31:0] prdata;
   wire  [1:0]       pready;
   wire  [1:0]       pslverr;
   logic [31:0]      pad_in;
   wire  [31:0]      pad_out;
   wire              irq;

   int          errors;
   int          checks;
   int          seed;
   int          last_served;
   time         done_time [2];
   // Set once the run cannot go on, no further bus traffic after that
   logic        aborted;
   // Pending first half of a contention pair
   logic        pend_valid;
   logic [11:0] pend_addr;
   logic [31:0] pend_mask;
   logic [31:0] pend_exp;
   logic        pend_err;
   logic [31:0] pair_rd [2];
   logic        pair_err [2];
   int          first;
   int          prev_first;
   logic        have_prev;

   periph_top dut_i (
      .clk,
      .rst_n,
      .m0_psel      (psel[0]),
      .m0_penable   (penable[0]),
      .m0_pwrite    (pwrite[0]),
      .m0_paddr     (paddr[0]),
      .m0_pwdata    (pwdata[0]),
      .m0_pstrb     (pstrb[0]),
      .m0_prdata    (prdata[0]),
      .m0_pready    (pready[0]),
      .m0_pslverr   (pslverr[0]),
      .m1_psel      (psel[1]),
      .m1_penable   (penable[1]),
      .m1_pwrite    (pwrite[1]),
      .m1_paddr     (paddr[1]),
      .m1_pwdata    (pwdata[1]),
      .m1_pstrb     (pstrb[1]),
      .m1_prdata    (prdata[1]),
      .m1_pready    (pready[1]),
      .m1_pslverr   (pslverr[1]),
      .gpio_pad_in  (pad_in),
      .gpio_pad_out (pad_out),
      .timer_irq    (irq)
   );

   // 10 ns clock
   initial clk = 1'b0;
   always #5 clk = ~clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      aborted = 1'b1;
   endtask

   // Masked compare, counts every check
   task automatic compare_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp, input logic [31:0] mask);
      // Results after a hang carry no meaning
      if (aborted) return;
      checks++;
      if ((got & mask) !== (exp & mask)) begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One APB transfer, entered and left on a falling edge
   task automatic apb_xfer(input int m, input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic wr,
                           output logic [31:0] rd, output logic err);
      int cnt;
      // Setup phase
      psel[m]   = 1'b1;
      pwrite[m] = wr;
      paddr[m]  = addr;
      pwdata[m] = data;
      pstrb[m]  = wr ? strb : 4'h0;
      @(negedge clk);
      penable[m] = 1'b1;
      cnt = 0;
      // Hold until the subsystem answers
      while (!pready[m] && !aborted) begin
         @(negedge clk);
         cnt++;
         if (cnt > 50 && !pready[m]) begin
            stop_run($sformatf("Timeout: master m%0d never returned pready", m));
         end
      end
      rd = prdata[m];
      err = pslverr[m];
      done_time[m] = $time;
      last_served = m;
      @(negedge clk);
      psel[m]    = 1'b0;
      penable[m] = 1'b0;
      pwrite[m]  = 1'b0;
      pstrb[m]   = 4'h0;
   endtask

   task automatic wait_irq(input logic level);
      int cnt;
      cnt = 0;
      while (irq !== level && !aborted) begin
         @(negedge clk);
         cnt++;
         if (cnt > 500 && irq !== level) begin
            stop_run($sformatf("Timeout: timer_irq never went to %0b", level));
         end
      end
      checks++;
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      byte         op;
      int          m;
      int          exp_err;
      int          exp_first;
      logic [11:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      logic [31:0] exp_val;
      logic [31:0] rd;
      logic        er;
      logic [31:0] pad_val;
      psel        = '0;
      penable     = '0;
      pwrite      = '0;
      paddr       = '0;
      pwdata      = '0;
      pstrb       = '0;
      pad_in      = '0;
      rst_n       = 1'b1;
      seed        = 32'h5357;
      errors      = 0;
      checks      = 0;
      aborted     = 1'b0;
      last_served = 1;
      pend_valid  = 1'b0;
      have_prev   = 1'b0;
      prev_first  = 0;
      repeat (8) @(negedge clk);
      rst_n = 1'b0;
      @(negedge clk);
      // Idle state right after reset
      compare_word("gpio_pad_out after reset", pad_out, 32'h0, '1);
      compare_word("timer_irq after reset", irq, 32'h0, 32'h1);
      compare_word("pready while idle", pready, 32'h0, 32'h3);
      fd = $fopen("testbench/periph_patterns.txt", "r");
      if (fd == 0) begin
         stop_run("Could not open testbench/periph_patterns.txt");
      end
      while (!aborted && !$feof(fd)) begin
         if ($fgets(line, fd) == 0) break;
         // Skip comments and blank lines
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%c %d %h %h %h %h %d", op, m, addr, data, strb, exp_val, exp_err);
         if (n != 7) begin
            errors++;
            $display("Pattern line could not be parsed: %s", line);
            continue;
         end
         case (op)
            "W": begin
               apb_xfer(m, addr, data, strb, 1'b1, rd, er);
               compare_word("write pslverr", er, exp_err, 32'h1);
               compare_word("gpio_pad_out after write", pad_out, exp_val, '1);
            end
            "R": begin
               // Data column is the compare mask
               apb_xfer(m, addr, 32'h0, 4'h0, 1'b0, rd, er);
               compare_word("read data", rd, exp_val, data);
               compare_word("read pslverr", er, exp_err, 32'h1);
            end
            "P": begin
               pad_val = $random(seed);
               pad_in = pad_val;
               // Two cycles through the synchronizer
               repeat (2) @(negedge clk);
               apb_xfer(m, addr, 32'h0, 4'h0, 1'b0, rd, er);
               compare_word("pad input readback", rd, pad_val, '1);
               compare_word("pad read pslverr", er, 32'h0, 32'h1);
            end
            "I": wait_irq(exp_val[0]);
            "C": begin
               if (!pend_valid) begin
                  pend_valid = 1'b1;
                  pend_addr  = addr;
                  pend_mask  = data;
                  pend_exp   = exp_val;
                  pend_err   = (exp_err != 0);
               end else begin
                  pend_valid = 1'b0;
                  // Round robin, the master not served last wins the tie
                  exp_first = (last_served == 0) ? 1 : 0;
                  fork
                     apb_xfer(0, pend_addr, 32'h0, 4'h0, 1'b0, pair_rd[0], pair_err[0]);
                     apb_xfer(1, addr, 32'h0, 4'h0, 1'b0, pair_rd[1], pair_err[1]);
                  join
                  compare_word("m0 data in contention", pair_rd[0], pend_exp, pend_mask);
                  compare_word("m1 data in contention", pair_rd[1], exp_val, data);
                  compare_word("m0 pslverr in contention", pair_err[0], pend_err, 32'h1);
                  compare_word("m1 pslverr in contention", pair_err[1], exp_err, 32'h1);
                  first = (done_time[1] < done_time[0]) ? 1 : 0;
                  compare_word("first master to complete", first, exp_first, 32'h1);
                  checks++;
                  if (!aborted && have_prev && first == prev_first) begin
                     errors++;
                     $display("** Error at %0t: first completion did not alternate", $time);
                  end
                  have_prev  = 1'b1;
                  prev_first = first;
               end
            end
            default: begin
               errors++;
               $display("Unknown opcode in pattern line: %s", line);
            end
         endcase
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0 && !aborted) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* testbench/periph_patterns.txt */
# op master addr data strb expect err (hex except master and err)
# W data is write data and expect the pads after it, R/C data is the read mask, I waits irq=expect
W 0 000 12345678 f 12345678 0
R 1 000 ffffffff 0 12345678 0
W 1 000 0000ab00 2 1234ab78 0
W 0 000 cd000000 8 cd34ab78 0
R 0 000 ffffffff 0 cd34ab78 0
P 0 004 00000000 0 00000000 0
P 1 004 00000000 0 00000000 0
W 0 200 ffffffff f cd34ab78 1
R 1 200 ffffffff 0 00000000 1
W 0 108 00000040 f cd34ab78 0
W 0 104 00000000 f cd34ab78 0
W 0 100 00000001 f cd34ab78 0
R 1 104 ffffff00 0 00000000 0
I 0 000 00000000 0 00000001 0
R 0 10c ffffffff 0 00000001 0
W 1 10c 00000001 1 cd34ab78 0
I 0 000 00000000 0 00000000 0
R 0 10c ffffffff 0 00000000 0
W 0 100 00000000 f cd34ab78 0
W 0 104 00001234 f cd34ab78 0
R 1 104 ffffffff 0 00001234 0
C 0 000 ffffffff 0 cd34ab78 0
C 1 104 ffffffff 0 00001234 0
R 0 108 ffffffff 0 00000040 0
C 0 108 ffffffff 0 00000040 0
C 1 10c ffffffff 0 00000000 0
R 1 000 ffffffff 0 cd34ab78 0
C 0 104 ffffffff 0 00001234 0
C 1 000 ffffffff 0 cd34ab78 0

/* build.f */
source/periph_pkg.sv
source/periph_arbiter.sv
source/periph_bus_decode.sv
source/periph_gpio_ctrl.sv
source/periph_timer.sv
source/periph_top.sv
testbench/periph_tb.sv
